// ==== rtl/busMasterPkg.sv ====
package busMasterPkg;

    // data byte
    localparam int DATA_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0] dataT;

    //////////////////////////////
    // control frame goes out MSB first
    localparam int         CONTROL_LEN = 7;
    localparam logic [1:0] FRAME_START = 2'b11;
    localparam logic [2:0] SLAVE_ID    = 3'b100;

    typedef struct packed {
        logic [1:0] start;    // always 2'b11
        logic [2:0] slaveId;
        logic       write;    // 1 = write
        logic       burst;    // single byte only
    } ctrlFrameT;

    //////////////////////////////
    // arbiter line patterns
    localparam int REQ_LEN = 6;
    localparam int ACK_LEN = 3;
    localparam int REL_LEN = 4;

    // request is three ones then the slave id
    localparam logic [REQ_LEN-1:0] REQ_BITS = {3'b111, SLAVE_ID};
    localparam logic [ACK_LEN-1:0] ACK_BITS = 3'b101;
    localparam logic [REL_LEN-1:0] REL_BITS = 4'b0110;

    //////////////////////////////
    // session
    localparam int INCR_HOLD = 4;    // cycles spent showing the read byte

endpackage : busMasterPkg

// ==== rtl/txnIf.sv ====
`timescale 1ns/1ps

// session control <-> transfer engine
interface txnIf;

    logic               go;         // one-cycle pulse with no txn open
    logic               isWrite;    // held until done
    busMasterPkg::dataT wrData;     // held until done
    logic               done;       // one-cycle pulse
    busMasterPkg::dataT rdData;     // valid with done

    modport ses (
        output go, isWrite, wrData,
        input  done, rdData
    );

    modport eng (
        input  go, isWrite, wrData,
        output done, rdData
    );

endinterface : txnIf

// ==== rtl/arbIf.sv ====
`timescale 1ns/1ps

// all pulses between transfer engine and arbiter handshake
interface arbIf;

    logic req;
    logic granted;      // one per req
    logic releaseReq;
    logic released;     // one per releaseReq

    modport eng (
        output req, releaseReq,
        input  granted, released
    );

    modport arb (
        input  req, releaseReq,
        output granted, released
    );

endinterface : arbIf

// ==== rtl/serialShifter.sv ====
`timescale 1ns/1ps

module serialShifter #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    load,
    input  payloadT loadValue,
    input  logic    shiftEn,
    input  logic    serIn,
    output logic    serOut,
    output payloadT value
);

    logic [$bits(payloadT)-1:0] shiftReg;

    // load wins over shift
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '0;
        end else if (load) begin
            shiftReg <= loadValue;
        end else if (shiftEn) begin
            shiftReg <= {shiftReg[$bits(payloadT)-2:0], serIn};    // toward MSB
        end
    end

    assign serOut = shiftReg[$bits(payloadT)-1];
    assign value  = payloadT'(shiftReg);

endmodule : serialShifter

// ==== rtl/arbiterHandshake.sv ====
`timescale 1ns/1ps

module arbiterHandshake (
    input  logic clk,
    input  logic rstN,
    arbIf.arb    arb,
    output logic arbSend,
    input  logic arbCont
);

    typedef enum logic [2:0] {
        idle,
        sendReq,
        waitGrant,
        sendAck,
        owned,
        sendRel
    } stateT;

    // wide enough for the longest pattern
    typedef logic [$clog2(busMasterPkg::REQ_LEN)-1:0] cntT;

    stateT      state;
    cntT        bitCnt;     // counts down as bit index into pattern
    logic [1:0] contHist;   // last two arbCont samples

    //////////////////////////////
    // pattern sequencing

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= idle;
            bitCnt       <= '0;
            contHist     <= '0;
            arb.granted  <= 1'b0;
            arb.released <= 1'b0;
        end else begin
            contHist     <= {contHist[0], arbCont};
            arb.granted  <= 1'b0;
            arb.released <= 1'b0;

            case (state)
                idle: begin
                    if (arb.req) begin
                        state  <= sendReq;
                        bitCnt <= cntT'(busMasterPkg::REQ_LEN - 1);
                    end
                end
                sendReq: begin
                    if (bitCnt == '0) begin
                        state <= waitGrant;
                    end else begin
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                waitGrant: begin
                    // arbiter may keep us waiting here
                    if (contHist == 2'b11) begin
                        state  <= sendAck;
                        bitCnt <= cntT'(busMasterPkg::ACK_LEN - 1);
                    end
                end
                sendAck: begin
                    if (bitCnt == '0) begin
                        state       <= owned;
                        arb.granted <= 1'b1;
                    end else begin
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                owned: begin
                    if (arb.releaseReq) begin
                        state  <= sendRel;
                        bitCnt <= cntT'(busMasterPkg::REL_LEN - 1);
                    end
                end
                sendRel: begin
                    if (bitCnt == '0) begin
                        state        <= idle;
                        arb.released <= 1'b1;
                    end else begin
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    //////////////////////////////
    // serial line to arbiter

    always_comb begin
        case (state)
            sendReq: arbSend = busMasterPkg::REQ_BITS[bitCnt];
            sendAck: arbSend = busMasterPkg::ACK_BITS[bitCnt[1:0]];
            sendRel: arbSend = busMasterPkg::REL_BITS[bitCnt[1:0]];
            default: arbSend = 1'b0;    // quiet while waiting or owning
        endcase
    end

endmodule : arbiterHandshake

// ==== rtl/transferEngine.sv ====
`timescale 1ns/1ps

module transferEngine (
    input  logic clk,
    input  logic rstN,
    txnIf.eng    txn,
    arbIf.eng    arb,
    output logic control,
    output logic wrD,
    output logic valid,
    input  logic rD,
    input  logic ready
);

    typedef enum logic [2:0] {
        idle,
        waitGrant,
        sendFrame,
        moveData,
        sendRelease,
        waitRelease
    } stateT;

    // covers both frame and data bit counts
    typedef logic [$clog2(busMasterPkg::DATA_WIDTH)-1:0] cntT;

    stateT                   state;
    cntT                     bitCnt;
    busMasterPkg::ctrlFrameT frame;
    logic                    loadAll;
    logic                    frameShift;
    logic                    dataShift;
    logic                    dataIn;
    logic                    dataMsb;

    always_comb begin
        frame.start   = busMasterPkg::FRAME_START;
        frame.slaveId = busMasterPkg::SLAVE_ID;
        frame.write   = txn.isWrite;
        frame.burst   = 1'b0;
    end

    // both shifters load on grant and data waits out the frame
    assign loadAll    = (state == waitGrant) && arb.granted;
    assign frameShift = (state == sendFrame);
    assign dataShift  = (state == moveData) && (txn.isWrite || ready);
    assign dataIn     = txn.isWrite ? 1'b0 : rD;   // zeros behind outgoing bits

    //////////////////////////////
    // shifters

    serialShifter #(.payloadT(busMasterPkg::ctrlFrameT)) frameShifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (loadAll),
        .loadValue (frame),
        .shiftEn   (frameShift),
        .serIn     (1'b0),
        .serOut    (control),
        .value     ()
    );

    serialShifter #(.payloadT(busMasterPkg::dataT)) dataShifter (
        .clk       (clk),
        .rstN      (rstN),
        .load      (loadAll),
        .loadValue (txn.wrData),
        .shiftEn   (dataShift),
        .serIn     (dataIn),
        .serOut    (dataMsb),
        .value     (txn.rdData)
    );

    //////////////////////////////
    // phase sequencing

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= idle;
            bitCnt <= '0;
            valid  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (txn.go) state <= waitGrant;
                end
                waitGrant: begin
                    if (arb.granted) begin
                        state  <= sendFrame;
                        bitCnt <= cntT'(busMasterPkg::CONTROL_LEN - 1);
                    end
                end
                sendFrame: begin
                    if (bitCnt == '0) begin
                        state  <= moveData;
                        bitCnt <= cntT'(busMasterPkg::DATA_WIDTH - 1);
                        valid  <= txn.isWrite;
                    end else begin
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                moveData: begin
                    // reads stall on ready low
                    if (dataShift) begin
                        if (bitCnt == '0) begin
                            state <= sendRelease;
                            valid <= 1'b0;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                sendRelease: state <= waitRelease;
                waitRelease: begin
                    if (arb.released) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    assign arb.req        = (state == idle) && txn.go;
    assign arb.releaseReq = (state == sendRelease);
    assign txn.done       = (state == waitRelease) && arb.released;
    assign wrD            = dataMsb & valid;

endmodule : transferEngine

// ==== rtl/sessionControl.sv ====
`timescale 1ns/1ps

module sessionControl (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  logic               eoc,
    output logic               doneCom,
    output busMasterPkg::dataT dataOut,
    txnIf.ses                  txn
);

    typedef enum logic [2:0] {
        idle,
        reading,
        incrementing,
        writing,
        finished
    } phaseT;

    typedef logic [$clog2(busMasterPkg::INCR_HOLD)-1:0] holdT;

    phaseT              phase;
    holdT               holdCnt;
    busMasterPkg::dataT dataReg;   // byte to write back
    logic               goQ;

    //////////////////////////////
    // read, increment, write loop

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase   <= idle;
            holdCnt <= '0;
            dataReg <= '0;
            dataOut <= '0;
            goQ     <= 1'b0;
        end else begin
            goQ <= 1'b0;
            case (phase)
                idle: begin
                    if (eoc) begin
                        phase <= finished;
                    end else begin
                        goQ   <= 1'b1;
                        phase <= start ? writing : reading;
                    end
                end
                reading: begin
                    if (txn.done) begin
                        dataOut <= txn.rdData;
                        dataReg <= txn.rdData + 1'b1;   // wraps at 255
                        holdCnt <= holdT'(busMasterPkg::INCR_HOLD - 1);
                        phase   <= incrementing;
                    end
                end
                incrementing: begin
                    if (holdCnt == '0) begin
                        goQ   <= 1'b1;
                        phase <= writing;
                    end else begin
                        holdCnt <= holdCnt - 1'b1;
                    end
                end
                writing: begin
                    if (txn.done) begin
                        if (eoc) begin
                            phase <= finished;
                        end else begin
                            goQ   <= 1'b1;
                            phase <= reading;
                        end
                    end
                end
                finished: phase <= finished;     // only reset leaves
                default:  phase <= idle;
            endcase
        end
    end

    assign txn.go      = goQ;
    assign txn.isWrite = (phase == writing);   // stable until done
    assign txn.wrData  = dataReg;
    assign doneCom     = (phase == finished);

endmodule : sessionControl

// ==== rtl/busMaster.sv ====
`timescale 1ns/1ps

module busMaster (
    input  logic               clk,
    input  logic               rstN,

    // user side
    input  logic               start,
    input  logic               eoc,
    output logic               doneCom,
    output busMasterPkg::dataT dataOut,

    // slave side
    output logic               control,
    output logic               wrD,
    output logic               valid,
    input  logic               rD,
    input  logic               ready,

    // arbiter side
    output logic               arbSend,
    input  logic               arbCont
);

    txnIf txnBus ();
    arbIf arbBus ();

    sessionControl session (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .eoc     (eoc),
        .doneCom (doneCom),
        .dataOut (dataOut),
        .txn     (txnBus.ses)
    );

    transferEngine engine (
        .clk     (clk),
        .rstN    (rstN),
        .txn     (txnBus.eng),
        .arb     (arbBus.eng),
        .control (control),
        .wrD     (wrD),
        .valid   (valid),
        .rD      (rD),
        .ready   (ready)
    );

    arbiterHandshake handshake (
        .clk     (clk),
        .rstN    (rstN),
        .arb     (arbBus.arb),
        .arbSend (arbSend),
        .arbCont (arbCont)
    );

endmodule : busMaster

// ==== tb/busMaster_asserts.sv ====
`timescale 1ns/1ps

module busMaster_asserts (
    input logic clk,
    input logic rstN,
    input logic valid,
    input logic control,
    input logic doneCom,
    input logic arbSend
);

    // frame and data never overlap on the slave side
    noFrameDuringData: assert property (
        @(posedge clk) disable iff (!rstN) !(valid && control)
    ) else $error("valid and control high together");

    doneSticks: assert property (
        @(posedge clk) disable iff (!rstN) doneCom |=> doneCom
    ) else $error("doneCom fell without reset");

    quietInReset: assert property (
        @(posedge clk) !rstN |-> !arbSend
    ) else $error("arbSend high during reset");

endmodule : busMaster_asserts

bind busMaster busMaster_asserts protocolChecks (
    .clk     (clk),
    .rstN    (rstN),
    .valid   (valid),
    .control (control),
    .doneCom (doneCom),
    .arbSend (arbSend)
);

// ==== tb/busMasterTb.sv ====
`timescale 1ns/1ps

module busMasterTb;

    localparam int TIMEOUT   = 200;    // cycles allowed per wait
    localparam int ROUNDS    = 6;
    localparam int SIG_ARB   = 0;
    localparam int SIG_CTRL  = 1;
    localparam int SIG_VALID = 2;
    localparam int SIG_DONE  = 3;

    logic clk, rstN, start, eoc, doneCom;
    logic control, wrD, valid, rD, ready, arbSend, arbCont;
    busMasterPkg::dataT dataOut;

    integer     seed;
    int         errCnt, checkCnt, testCnt, errMark;
    logic [7:0] expData;    // model of dataOut
    logic [7:0] expReg;     // model of the byte written back
    logic [7:0] slaveByte, gotByte;
    event       abortEv;

    busMaster UUT (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc), .doneCom(doneCom),
        .dataOut(dataOut), .control(control), .wrD(wrD), .valid(valid), .rD(rD),
        .ready(ready), .arbSend(arbSend), .arbCont(arbCont)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // helpers

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        -> abortEv;
        forever @(posedge clk);
    endtask

    task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] exp);
        checkCnt++;
        assert (got === exp) else begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errCnt++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCnt++;
        $display("test %0d, %s: %0d errors", testCnt, name, errCnt - errBefore);
    endtask

    function automatic logic pick(input int sel);
        case (sel)
            SIG_ARB:   return arbSend;
            SIG_CTRL:  return control;
            SIG_VALID: return valid;
            default:   return doneCom;
        endcase
    endfunction

    task automatic waitHigh(input int sel, input string what);
        int n;
        n = 0;
        while (!pick(sel)) begin
            if (n == TIMEOUT) abortRun({"timeout: no ", what, " seen"});
            tick();
            n++;
        end
    endtask

    // starts on the current sample and goes MSB first
    task automatic checkPattern(input int sel, input string name, input logic [7:0] exp,
                                input int len);
        logic [7:0] bits;
        bits = exp << (8 - len);
        for (int i = len - 1; i >= 0; i--) begin
            checkValue($sformatf("%s[%0d]", name, i), {7'd0, pick(sel)}, {7'd0, bits[7]});
            bits = bits << 1;
            if (i > 0) tick();
        end
    endtask

    //////////////////////////////
    // one transaction with arbiter and slave modelled inline

    task automatic runTxn(input logic isWrite, input logic [7:0] rdByte,
                          output logic [7:0] wrByte);
        int         n;
        int         left;
        logic [7:0] pending;
        wrByte = 8'h00;
        waitHigh(SIG_ARB, "arbitration request");
        checkPattern(SIG_ARB, "arbSend", 8'b0011_1100, 6);
        repeat ($random(seed) & 7) tick();    // arbiter busy elsewhere
        arbCont = 1'b1;
        waitHigh(SIG_ARB, "grant acknowledge");
        checkPattern(SIG_ARB, "arbSend", 8'b0000_0101, 3);
        waitHigh(SIG_CTRL, "control frame");
        checkPattern(SIG_CTRL, "control", {1'b0, 5'b11100, isWrite, 1'b0}, 7);
        if (isWrite) begin
            waitHigh(SIG_VALID, "write data");
            repeat (8) begin
                checkValue("valid", {7'd0, valid}, 8'h01);
                wrByte = {wrByte[6:0], wrD};
                tick();
            end
            checkValue("valid", {7'd0, valid}, 8'h00);
        end else begin
            tick();    // first data cycle
            pending = rdByte;
            left    = 8;
            n       = 0;
            while (left > 0) begin
                if (n == TIMEOUT) abortRun("timeout: read data phase never completed");
                ready = (($random(seed) & 3) != 0);    // roughly one gap in four
                rD    = ready ? pending[7] : 1'($random(seed));
                tick();
                if (ready) begin
                    pending = pending << 1;
                    left--;
                end
                n++;
            end
            ready = 1'b0;
            rD    = 1'b0;
        end
        tick();    // release pulse
        checkPattern(SIG_ARB, "arbSend", 8'b0000_0110, 4);
        arbCont = 1'b0;
    endtask

    //////////////////////////////
    // session sequence

    initial begin
        @(abortEv);
        $display("test failed");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;
        start   = 1'b1;
        eoc     = 1'b0;
        rD      = 1'b0;
        ready   = 1'b0;
        arbCont = 1'b0;
        seed    = 32'h00eb_6787;
        errCnt   = 0;
        checkCnt = 0;
        testCnt  = 0;
        expReg  = 8'h00;
        expData = 8'h00;

        errMark = errCnt;
        repeat (5) tick();
        checkValue("arbSend", {7'd0, arbSend}, 8'h00);
        checkValue("control", {7'd0, control}, 8'h00);
        checkValue("wrD", {7'd0, wrD}, 8'h00);
        checkValue("valid", {7'd0, valid}, 8'h00);
        checkValue("doneCom", {7'd0, doneCom}, 8'h00);
        checkValue("dataOut", dataOut, 8'h00);
        reportTest("reset values", errMark);
        rstN = 1'b1;
        tick();
        start = 1'b0;    // session already left idle

        errMark = errCnt;
        runTxn(1'b1, 8'h00, gotByte);
        checkValue("wrD", gotByte, expReg);
        reportTest("first write", errMark);

        for (int r = 1; r <= ROUNDS; r++) begin
            errMark   = errCnt;
            slaveByte = (r == 3) ? 8'hff : 8'($random(seed));    // one wrap case
            runTxn(1'b0, slaveByte, gotByte);
            expData = slaveByte;
            expReg  = slaveByte + 8'd1;
            if (r == ROUNDS) eoc = 1'b1;
            runTxn(1'b1, 8'h00, gotByte);
            checkValue("dataOut", dataOut, expData);
            checkValue("wrD", gotByte, expReg);
            reportTest($sformatf("read 0x%h, write back", slaveByte), errMark);
        end

        errMark = errCnt;
        waitHigh(SIG_DONE, "doneCom");
        eoc = 1'b0;
        repeat (20) begin
            tick();
            checkValue("doneCom", {7'd0, doneCom}, 8'h01);
            checkValue("dataOut", dataOut, expData);
            checkValue("arbSend", {7'd0, arbSend}, 8'h00);
        end
        reportTest("session done", errMark);

        $display("%0d tests, %0d checks, %0d errors", testCnt, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : busMasterTb

// ==== flist.f ====
rtl/busMasterPkg.sv
rtl/txnIf.sv
rtl/arbIf.sv
rtl/serialShifter.sv
rtl/arbiterHandshake.sv
rtl/transferEngine.sv
rtl/sessionControl.sv
rtl/busMaster.sv
tb/busMaster_asserts.sv
tb/busMasterTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
rm -rf obj_dir
verilator --binary --assert --top-module busMasterTb -f flist.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VbusMasterTb > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }
grep -q "test failed" sim.log && exit 1 || exit 0
